//--- verif/gauntlet_vectors.txt
# B idx addr data | W region addr data | E no write | K code pressed | J stick value
# R mem_ready | T dl_wait | V variant | P p1 p2 p3 p4 sys (all hex)
V 68
R 0
T 1
R 1
T 0
P FF FF FF FF 1F
B 00 000000 11
B 00 000001 22
B 00 000002 33
B 00 000003 44
W 0 0000 11223344
B 00 0C0000 AB
B 00 0C0001 CD
W 1 0000 0000ABCD
B 00 140005 5A
W 7 0005 0000005A
B 00 0D0000 77
B 00 0D0001 88
E
B 00 14C003 9E
W 9 0003 0000009E
K 175 1
P 7F FF FF FF 1F
K 175 0
P FF FF FF FF 1F
J 2 0008
P FF FF 7F FF 1F
J 2 0000
K 02E 1
P FF FF FF FF 17
K 02E 0
J 3 0100
P FF FF FF FF 1E
J 3 0000
B 01 000000 76
V 76
K 023 1
P 7F FF FF FF 1F
K 023 0
J 0 0008
P CF FF FF FF 1F
J 0 0200
P FF FF FE FF 1F
J 0 0000
P FF FF FF FF 1F

//--- list.f
+incdir+common
common/gauntlet_pkg.sv
rom_loader/rom_region_decode.sv
rom_loader/download_writer.sv
controls/tank_tread_decode.sv
controls/control_mapper.sv
logic/gauntlet_io_top.sv
verif/tb_gauntlet_io.sv

//--- Makefile
TOP = tb_gauntlet_io

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- verif/tb_gauntlet_io.sv
// Gauntlet I/O glue testbench
// Replays verif/gauntlet_vectors.txt against the top level and compares
// ROM writes, download wait, variant and player/system ports
`timescale 1ns/1ns

module tb_gauntlet_io import gauntlet_pkg::*; ();

	localparam int WAIT_LIMIT = 50; // Cycles before a wait gives up

	logic clk_sys;
	logic rst;
	logic dl_strobe;
	dl_byte_t dl_byte;
	logic downloading;
	logic mem_ready;
	key_event_t key;
	joy_t joy0, joy1, joy2, joy3;
	logic service;
	logic rom_wr_valid;
	rom_wr_t rom_wr;
	logic dl_wait;
	variant_t variant;
	player_t p1, p2, p3, p4;
	logic [4:0] sys;

	rom_wr_t wr_q[$]; // Writes seen on the bus in arrival order

	gauntlet_io_top dut0 (
		.clk_sys(clk_sys), .rst(rst),
		.dl_strobe(dl_strobe), .dl_byte(dl_byte),
		.downloading(downloading), .mem_ready(mem_ready),
		.key(key), .joy0(joy0), .joy1(joy1), .joy2(joy2), .joy3(joy3),
		.service(service),
		.rom_wr_valid(rom_wr_valid), .rom_wr(rom_wr),
		.dl_wait(dl_wait), .variant(variant),
		.p1(p1), .p2(p2), .p3(p3), .p4(p4), .sys(sys)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	// Write pulses sampled mid-cycle
	always @(negedge clk_sys) begin
		if (!rst && rom_wr_valid) wr_q.push_back(rom_wr);
	end

	// ############################################################
	// Stop and compare tasks
	// ############################################################
	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic fail_with(input string what);
		$display("%0t ns: %s", $time, what);
		stop_run();
	endtask

	task automatic check_wr(input rom_wr_t got, input rom_wr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns rom_wr: expected %s addr %h data %h, got %s addr %h data %h",
				$time, exp.region.name(), exp.addr, exp.data,
				got.region.name(), got.addr, got.data);
			stop_run();
		end
	endtask

	task automatic check_player(input string name, input player_t got, input player_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: expected %h, got %h", $time, name, exp, got);
			stop_run();
		end
	endtask

	task automatic check_sys(input logic [4:0] got, input logic [4:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns sys: expected %b, got %b", $time, exp, got);
			stop_run();
		end
	endtask

	task automatic check_variant(input variant_t got, input variant_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns variant: expected %0d, got %0d", $time, exp, got);
			stop_run();
		end
	endtask

	task automatic check_wait(input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns dl_wait: expected %b, got %b", $time, exp, got);
			stop_run();
		end
	endtask

	// ############################################################
	// Stimulus tasks start and end 2 ns after a rising edge
	// ############################################################
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic settle();
		repeat (3) next_cycle(); // Ports and variant are stable by now
	endtask

	task automatic send_byte(input dl_index_t idx, input dl_addr_t addr, input logic [7:0] data);
		int n;
		n = 0;
		while (dl_wait) begin // Source holds off while memory is busy
			if (n >= WAIT_LIMIT) fail_with("dl_wait never dropped for a download byte");
			next_cycle();
			n++;
		end
		downloading = 1'b1;
		dl_byte.index = idx;
		dl_byte.addr = addr;
		dl_byte.data = data;
		dl_strobe = 1'b1;
		next_cycle();
		dl_strobe = 1'b0;
	endtask

	task automatic expect_write(input rom_wr_t exp);
		int n;
		n = 0;
		while (wr_q.size() == 0) begin
			if (n >= WAIT_LIMIT) fail_with("expected ROM write never arrived");
			next_cycle();
			n++;
		end
		check_wr(wr_q.pop_front(), exp);
	endtask

	task automatic expect_no_write();
		settle();
		if (wr_q.size() != 0) fail_with("a ROM write appeared where none was expected");
	endtask

	task automatic key_event(input key_code_t code, input logic pressed);
		key.code = code;
		key.pressed = pressed;
		key.toggle = ~key.toggle; // Edge marks the event
		next_cycle();
	endtask

	task automatic set_joy(input logic [1:0] sel, input joy_t value);
		case (sel)
			2'd0: joy0 = value;
			2'd1: joy1 = value;
			2'd2: joy2 = value;
			default: joy3 = value;
		endcase
		next_cycle();
	endtask

	// ############################################################
	// Vector replay
	// ############################################################
	initial begin
		int fd;
		int cnt;
		string line;
		logic [7:0] op;
		logic [31:0] f1, f2, f3, f4, f5;
		rom_wr_t exp;

		rst = 1'b1;
		dl_strobe = 1'b0;
		dl_byte = '0;
		downloading = 1'b0;
		mem_ready = 1'b1;
		key = '0;
		joy0 = '0;
		joy1 = '0;
		joy2 = '0;
		joy3 = '0;
		service = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		rst = 1'b0;

		fd = $fopen("verif/gauntlet_vectors.txt", "r");
		if (fd == 0) fail_with("cannot open verif/gauntlet_vectors.txt");
		while (!$feof(fd)) begin
			cnt = $fgets(line, fd);
			if (cnt == 0) break;
			if (line.len() < 2 || line.getc(0) == "#") continue; // Blank or comment
			cnt = $sscanf(line, "%c %h %h %h %h %h", op, f1, f2, f3, f4, f5);
			case (op)
				"B": send_byte(f1[7:0], f2[24:0], f3[7:0]);
				"W": begin
					exp.region = region_t'(f1[3:0]);
					exp.addr = f2[15:0];
					exp.data = f3;
					expect_write(exp);
				end
				"E": expect_no_write();
				"K": key_event(f1[8:0], f2[0]);
				"J": set_joy(f1[1:0], f2[15:0]);
				"R": begin
					mem_ready = f1[0];
					next_cycle();
				end
				"T": begin
					settle();
					check_wait(dl_wait, f1[0]);
				end
				"V": begin
					settle();
					check_variant(variant, f1[7:0]);
				end
				"P": begin
					if (cnt < 6) fail_with("port vector line has too few fields");
					settle();
					check_player("p1", p1, f1[7:0]);
					check_player("p2", p2, f2[7:0]);
					check_player("p3", p3, f3[7:0]);
					check_player("p4", p4, f4[7:0]);
					check_sys(sys, f5[4:0]);
				end
				default: fail_with("unknown operation in vector file");
			endcase
		end
		$fclose(fd);

		settle();
		if (wr_q.size() != 0) begin
			fail_with("ROM writes left over with no matching vector");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

//--- logic/gauntlet_io_top.sv
// Gauntlet I/O glue top level
// ROM download path feeding region writes, plus the control mapper
`timescale 1ns/1ns

module gauntlet_io_top import gauntlet_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input logic dl_strobe, // One cycle per byte
	input dl_byte_t dl_byte,
	input logic downloading,
	input logic mem_ready,
	input key_event_t key,
	input joy_t joy0,
	input joy_t joy1,
	input joy_t joy2,
	input joy_t joy3,
	input logic service,
	output logic rom_wr_valid,
	output rom_wr_t rom_wr,
	output logic dl_wait,
	output variant_t variant,
	output player_t p1,
	output player_t p2,
	output player_t p3,
	output player_t p4,
	output logic [4:0] sys
);

	rom_target_t target; // Decode of the current byte

	rom_region_decode u_decode (
		.dl_byte(dl_byte),
		.target(target)
	);

	download_writer u_writer (
		.clk_sys(clk_sys),
		.rst(rst),
		.dl_strobe(dl_strobe),
		.dl_byte(dl_byte),
		.downloading(downloading),
		.target(target),
		.mem_ready(mem_ready),
		.rom_wr_valid(rom_wr_valid),
		.rom_wr(rom_wr),
		.dl_wait(dl_wait),
		.variant(variant)
	);

	// Variant picks the key table
	control_mapper u_controls (
		.clk_sys(clk_sys),
		.rst(rst),
		.key(key),
		.joy0(joy0),
		.joy1(joy1),
		.joy2(joy2),
		.joy3(joy3),
		.service(service),
		.variant(variant),
		.p1(p1),
		.p2(p2),
		.p3(p3),
		.p4(p4),
		.sys(sys)
	);

endmodule

//--- controls/control_mapper.sv
// Control mapper
// Turns keyboard events and four joysticks into the active-low player
// ports and the service/coin byte, with a separate tank key table
`timescale 1ns/1ns
`include "gauntlet_consts.svh"

module control_mapper import gauntlet_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input key_event_t key,
	input joy_t joy0,
	input joy_t joy1,
	input joy_t joy2,
	input joy_t joy3,
	input logic service,
	input variant_t variant,
	output player_t p1,
	output player_t p2,
	output player_t p3,
	output player_t p4,
	output logic [4:0] sys // {service_n, coin1_n..coin4_n}
);

	logic tank; // Vindicators layout
	logic toggle_q;
	logic key_evt;
	player_t held_p1, held_p2, held_p3, held_p4; // Active high
	logic [3:0] held_coin; // Coin 1 in bit 0
	tread_t tread0, tread1;

	assign tank = (variant == `VAR_TANK);
	assign key_evt = key.toggle != toggle_q;

	// ############################################################
	// Key event tables
	// ############################################################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			toggle_q <= 1'b0;
			held_p1 <= '0;
			held_p2 <= '0;
			held_p3 <= '0;
			held_p4 <= '0;
			held_coin <= '0;
		end else begin
			toggle_q <= key.toggle;
			if (key_evt && tank) begin
				case (key.code)
					9'h023: held_p1[7] <= key.pressed; // D, right back
					9'h01B: held_p1[6] <= key.pressed; // S, left back
					9'h024: held_p1[5] <= key.pressed; // E, right fwd
					9'h01D: held_p1[4] <= key.pressed; // W, left fwd
					9'h02D: held_p1[3] <= key.pressed; // R thumb
					9'h015: held_p1[2] <= key.pressed; // Q thumb
					9'h02B: held_p1[1] <= key.pressed; // F trigger
					9'h01C: held_p1[0] <= key.pressed; // A trigger
					9'h042: held_p2[7] <= key.pressed; // K
					9'h03B: held_p2[6] <= key.pressed; // J
					9'h043: held_p2[5] <= key.pressed; // I
					9'h03C: held_p2[4] <= key.pressed; // U
					9'h044: held_p2[3] <= key.pressed; // O
					9'h035: held_p2[2] <= key.pressed; // Y
					9'h04B: held_p2[1] <= key.pressed; // L
					9'h033: held_p2[0] <= key.pressed; // H
					9'h016: held_p3[0] <= key.pressed; // 1, P1 start
					9'h01E: held_p3[1] <= key.pressed; // 2, P2 start
					9'h02E: held_coin[0] <= key.pressed; // 5
					9'h036: held_coin[1] <= key.pressed; // 6
					default: ;
				endcase
			end else if (key_evt) begin
				case (key.code)
					9'h175: held_p1[7] <= key.pressed; // Up arrow
					9'h172: held_p1[6] <= key.pressed; // Down arrow
					9'h16B: held_p1[5] <= key.pressed; // Left arrow
					9'h174: held_p1[4] <= key.pressed; // Right arrow
					9'h014: held_p1[1] <= key.pressed; // Left ctrl, fire
					9'h011: held_p1[0] <= key.pressed; // Left alt, magic
					9'h02D: held_p2[7] <= key.pressed; // R
					9'h02B: held_p2[6] <= key.pressed; // F
					9'h023: held_p2[5] <= key.pressed; // D
					9'h034: held_p2[4] <= key.pressed; // G
					9'h01C: held_p2[1] <= key.pressed; // A
					9'h01B: held_p2[0] <= key.pressed; // S
					9'h043: held_p3[7] <= key.pressed; // I
					9'h042: held_p3[6] <= key.pressed; // K
					9'h03B: held_p3[5] <= key.pressed; // J
					9'h04B: held_p3[4] <= key.pressed; // L
					9'h114: held_p3[1] <= key.pressed; // Right ctrl
					9'h059: held_p3[0] <= key.pressed; // Right shift
					9'h075: held_p4[7] <= key.pressed; // Numpad 8
					9'h072: held_p4[6] <= key.pressed; // Numpad 2
					9'h06B: held_p4[5] <= key.pressed; // Numpad 4
					9'h074: held_p4[4] <= key.pressed; // Numpad 6
					9'h070: held_p4[1] <= key.pressed; // Numpad 0
					9'h071: held_p4[0] <= key.pressed; // Numpad dot
					9'h02E: held_coin[0] <= key.pressed; // 5
					9'h036: held_coin[1] <= key.pressed; // 6
					9'h03D: held_coin[2] <= key.pressed; // 7
					9'h03E: held_coin[3] <= key.pressed; // 8
					default: ;
				endcase
			end
		end
	end

	// Sticks 0 and 1 drive the tanks
	tank_tread_decode u_tread (
		.clk_sys(clk_sys),
		.rst(rst),
		.stick_a(joy0[3:0]),
		.stick_b(joy1[3:0]),
		.tread_a(tread0),
		.tread_b(tread1)
	);

	// Normal port, stick high nibble and buttons low
	function automatic player_t merge(input player_t held, input joy_t j);
		return ~(held | {j[3:0], j[7:4]});
	endfunction

	// ############################################################
	// Port merge
	// ############################################################
	always_comb begin
		if (tank) begin
			p1 = ~(held_p1 | {tread0.right_bk, tread0.left_bk, tread0.right_fw,
				tread0.left_fw, joy0[7:4]});
			p2 = ~(held_p2 | {tread1.right_bk, tread1.left_bk, tread1.right_fw,
				tread1.left_fw, joy1[7:4]});
			p3 = ~(held_p3 | {6'b000000, joy1[9], joy0[9]}); // Stick starts
			p4 = ~held_p4; // Keys only
		end else begin
			p1 = merge(held_p1, joy0);
			p2 = merge(held_p2, joy1);
			p3 = merge(held_p3, joy2);
			p4 = merge(held_p4, joy3);
		end
	end

	assign sys = {~service,
		~(held_coin[0] | joy0[8]),
		~(held_coin[1] | joy1[8]),
		~(held_coin[2] | joy2[8]),
		~(held_coin[3] | joy3[8])};

endmodule

//--- controls/tank_tread_decode.sv
// Tank tread decoder
// Registered conversion of two 4-way sticks into tread forward/back bits
`timescale 1ns/1ns

module tank_tread_decode import gauntlet_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input logic [3:0] stick_a, // {up, down, left, right}
	input logic [3:0] stick_b,
	output tread_t tread_a,
	output tread_t tread_b
);

	// Eight-way stick to tread motion
	function automatic tread_t to_tread(input logic [3:0] s);
		tread_t t;
		t = '0;
		case (s)
			4'b1000: begin t.left_fw = 1'b1; t.right_fw = 1'b1; end // Up
			4'b0100: begin t.left_bk = 1'b1; t.right_bk = 1'b1; end // Down
			4'b0001: begin t.left_fw = 1'b1; t.right_bk = 1'b1; end // Right, spin
			4'b0010: begin t.left_bk = 1'b1; t.right_fw = 1'b1; end // Left, spin
			4'b1010: t.right_fw = 1'b1; // Up-left
			4'b1001: t.left_fw = 1'b1; // Up-right
			4'b0101: t.left_bk = 1'b1; // Down-right
			4'b0110: t.right_bk = 1'b1; // Down-left
			default: t = '0; // Idle or conflicting
		endcase
		return t;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tread_a <= '0;
			tread_b <= '0;
		end else begin
			tread_a <= to_tread(stick_a);
			tread_b <= to_tread(stick_b);
		end
	end

endmodule

//--- rom_loader/download_writer.sv
// Download writer
// Packs ROM bytes into dword, word or byte writes for the decoded region,
// keeps the game variant register and drives the download wait line
`timescale 1ns/1ns
`include "gauntlet_consts.svh"

module download_writer import gauntlet_pkg::*; (
	input logic clk_sys,
	input logic rst,
	input logic dl_strobe,
	input dl_byte_t dl_byte,
	input logic downloading,
	input rom_target_t target,
	input logic mem_ready,
	output logic rom_wr_valid,
	output rom_wr_t rom_wr,
	output logic dl_wait,
	output variant_t variant
);

	logic [23:0] acc; // Three previous ROM bytes, newest lowest
	logic rom_byte; // ROM stream byte this cycle
	logic is_rom; // Region backed by a real ROM
	rom_data_t wr_data;

	assign rom_byte = dl_strobe && downloading && (dl_byte.index == `DL_IDX_ROM);

	always_comb begin
		case (target.region)
			RGN_FILL, RGN_CONFIG, RGN_NONE: is_rom = 1'b0;
			default: is_rom = 1'b1;
		endcase
	end

	// Trim to region width, earlier bytes land higher
	always_comb begin
		case (target.region)
			RGN_GFX: wr_data = {acc, dl_byte.data};
			RGN_CPU_9AB, RGN_CPU_10AB, RGN_CPU_7AB,
			RGN_CPU_6AB, RGN_CPU_5AB, RGN_CPU_3AB:
				wr_data = {16'h0000, acc[7:0], dl_byte.data};
			default: wr_data = {24'h000000, dl_byte.data};
		endcase
	end

	// ############################################################
	// Accumulator and write record
	// ############################################################
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			acc <= '0;
			rom_wr_valid <= 1'b0;
		end else begin
			rom_wr_valid <= rom_byte && target.last && is_rom; // One-cycle strobe
			if (rom_byte) acc <= {acc[15:0], dl_byte.data}; // Fill bytes shift too
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_byte && target.last) begin
			rom_wr.region <= target.region;
			rom_wr.addr <= target.addr;
			rom_wr.data <= wr_data;
		end
	end

	// Variant byte arrives on index 1
	always_ff @(posedge clk_sys) begin
		if (rst) variant <= `VAR_DEFAULT;
		else if (dl_strobe && target.region == RGN_CONFIG) variant <= dl_byte.data;
	end

	assign dl_wait = ~mem_ready; // Holds off the next byte

endmodule

//--- rom_loader/rom_region_decode.sv
// ROM region decoder
// Maps a download byte's index and address onto a named ROM region,
// the word address inside it and whether the byte completes a word
`timescale 1ns/1ns
`include "gauntlet_consts.svh"

module rom_region_decode import gauntlet_pkg::*; (
	input dl_byte_t dl_byte,
	output rom_target_t target
);

	localparam dl_addr_t BASE_CPU_9AB = `ADDR_CPU_9AB;
	localparam dl_addr_t BASE_CPU_10AB = `ADDR_CPU_10AB;
	localparam dl_addr_t BASE_CPU_7AB = `ADDR_CPU_7AB;
	localparam dl_addr_t BASE_CPU_6AB = `ADDR_CPU_6AB;
	localparam dl_addr_t BASE_CPU_5AB = `ADDR_CPU_5AB;
	localparam dl_addr_t BASE_CPU_3AB = `ADDR_CPU_3AB;
	localparam dl_addr_t BASE_AUD_16S = `ADDR_AUD_16S;
	localparam dl_addr_t BASE_AUD_16R = `ADDR_AUD_16R;
	localparam dl_addr_t BASE_CHR_6P = `ADDR_CHR_6P;

	dl_addr_t a;
	assign a = dl_byte.addr;

	always_comb begin
		target.region = RGN_NONE;
		target.addr = '0;
		target.last = 1'b0;
		if (dl_byte.index == `DL_IDX_CFG) begin
			target.region = RGN_CONFIG;
		end else if (dl_byte.index == `DL_IDX_ROM) begin
			target.region = RGN_FILL; // Unless a ROM matches below
			if (a < BASE_CPU_9AB) begin
				target.region = RGN_GFX; // Four video ROMs interleaved
				target.addr = a[17:2];
				target.last = (a[1:0] == 2'b11);
			end else if (a[24:16] == BASE_CPU_9AB[24:16]) begin
				target.region = RGN_CPU_9AB;
				target.addr = {1'b0, a[15:1]};
				target.last = a[0]; // Odd byte ends the word
			end else if (a[24:15] == BASE_CPU_10AB[24:15]) begin
				target.region = RGN_CPU_10AB; // Half-size bank
				target.addr = {2'b00, a[14:1]};
				target.last = a[0];
			end else if (a[24:16] == BASE_CPU_7AB[24:16]) begin
				target.region = RGN_CPU_7AB;
				target.addr = {1'b0, a[15:1]};
				target.last = a[0];
			end else if (a[24:16] == BASE_CPU_6AB[24:16]) begin
				target.region = RGN_CPU_6AB;
				target.addr = {1'b0, a[15:1]};
				target.last = a[0];
			end else if (a[24:16] == BASE_CPU_5AB[24:16]) begin
				target.region = RGN_CPU_5AB;
				target.addr = {1'b0, a[15:1]};
				target.last = a[0];
			end else if (a[24:16] == BASE_CPU_3AB[24:16]) begin
				target.region = RGN_CPU_3AB;
				target.addr = {1'b0, a[15:1]};
				target.last = a[0];
			end else if (a[24:15] == BASE_AUD_16S[24:15]) begin
				target.region = RGN_AUD_16S;
				target.addr = {1'b0, a[14:0]};
				target.last = 1'b1; // Byte wide
			end else if (a[24:14] == BASE_AUD_16R[24:14]) begin
				target.region = RGN_AUD_16R;
				target.addr = {2'b00, a[13:0]};
				target.last = 1'b1;
			end else if (a[24:14] == BASE_CHR_6P[24:14]) begin
				target.region = RGN_CHR_6P;
				target.addr = {2'b00, a[13:0]};
				target.last = 1'b1;
			end
		end
	end

endmodule

//--- common/gauntlet_pkg.sv
// Gauntlet I/O shared types
// Download byte records, ROM write records, key events and tread bits
package gauntlet_pkg;

	typedef logic [24:0] dl_addr_t; // Download byte address
	typedef logic [7:0] dl_index_t; // Download index
	typedef logic [15:0] rom_addr_t; // Word address inside a region
	typedef logic [31:0] rom_data_t; // Right-aligned, earliest byte highest
	typedef logic [7:0] variant_t; // Game variant code
	typedef logic [7:0] player_t; // Player port, active low
	typedef logic [15:0] joy_t; // R,L,D,U, 4 buttons, coin, start
	typedef logic [8:0] key_code_t; // Extended scancode

	// ROM regions on the download stream
	typedef enum logic [3:0] {
		RGN_GFX, // Dword wide
		RGN_CPU_9AB, // Word wide from here
		RGN_CPU_10AB,
		RGN_CPU_7AB,
		RGN_CPU_6AB,
		RGN_CPU_5AB,
		RGN_CPU_3AB,
		RGN_AUD_16S, // Byte wide from here
		RGN_AUD_16R,
		RGN_CHR_6P,
		RGN_FILL, // Gap in ROM space
		RGN_CONFIG, // Index 1 byte
		RGN_NONE
	} region_t;

	typedef struct packed {
		dl_index_t index;
		dl_addr_t addr;
		logic [7:0] data;
	} dl_byte_t;

	typedef struct packed {
		region_t region;
		rom_addr_t addr;
		logic last; // Byte completes the region's word
	} rom_target_t;

	typedef struct packed {
		region_t region;
		rom_addr_t addr;
		rom_data_t data;
	} rom_wr_t;

	typedef struct packed {
		logic toggle; // Flips on every event
		logic pressed;
		key_code_t code;
	} key_event_t;

	typedef struct packed {
		logic left_fw;
		logic left_bk;
		logic right_fw;
		logic right_bk;
	} tread_t;

endpackage

//--- common/gauntlet_consts.svh
// Gauntlet I/O glue constants
// Download indices, game variant codes and the ROM download address map
`ifndef GAUNTLET_CONSTS_SVH
`define GAUNTLET_CONSTS_SVH

// Download index values
`define DL_IDX_ROM 8'd0 // ROM image stream
`define DL_IDX_CFG 8'd1 // Variant config byte

// Game variant codes, as loaded through index 1
`define VAR_DEFAULT 8'd104 // Gauntlet
`define VAR_TANK 8'd118 // Vindicators Part II

// ############################################################
// Download address map, byte addresses
// Graphics occupies 000000 up to the 9AB base
// ############################################################
`define ADDR_CPU_9AB 25'h0C0000 // 64 KB, 0D0000..0EFFFF is fill
`define ADDR_CPU_10AB 25'h0F0000 // 2x16 KB, 0F8000..0FFFFF is fill
`define ADDR_CPU_7AB 25'h100000
`define ADDR_CPU_6AB 25'h110000
`define ADDR_CPU_5AB 25'h120000
`define ADDR_CPU_3AB 25'h130000
`define ADDR_AUD_16S 25'h140000 // 32 KB
`define ADDR_AUD_16R 25'h148000 // 16 KB
`define ADDR_CHR_6P 25'h14C000 // 16 KB

`endif
